// File: filelist.f
common/forth_pkg.sv
core/lifo_stack.sv
core/forth_core.sv
verilog/boot_rom.sv
uart/uart_rx.sv
uart/uart_tx.sv
verilog/forth_proc.sv
bench/forth_proc_asserts.sv
bench/forth_proc_tb.sv

// File: bench/forth_proc_tb.sv
// Directed tests of the stack processor through its UART pins and LED port.
// UART runs at 16 clocks per bit, rx is driven and tx is sampled at mid-bit.
// Outputs are sampled on the falling clock edge.
`default_nettype none

module forth_proc_tb;
	import forth_pkg::*;

	localparam int bit_clks = 16;
	localparam int clk_period = 20;
	localparam int num_bytes = 26;
	// Three frames per byte covers the echo and any wait behind an earlier frame
	localparam int watchdog_time = num_bytes * 3 * 10 * bit_clks * clk_period + 50000;
	localparam int start_wait_cycles = 40 * bit_clks;

	logic       clk;
	logic       reset;
	logic       rx;
	logic       tx;
	logic [7:0] led;
	int         error_count;
	int         check_count;
	int         assert_failures;
	int unsigned seed;

	forth_proc #(
		.clks_per_bit(bit_clks)
	) forth_proc_i (
		.clk  (clk),
		.reset(reset),
		.rx   (rx),
		.tx   (tx),
		.led  (led)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t: %s expected 8'h%02h, got 8'h%02h",
				$time, name, expected, actual);
		end
	endtask

	task automatic check_led(input logic [7:0] expected, input logic [7:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t: led expected 8'h%02h, got 8'h%02h",
				$time, expected, actual);
		end
	endtask

	// One 8N1 frame on rx, each bit held for bit_clks cycles
	task automatic send_byte(input byte_t data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			rx <= frame[i];
			repeat (bit_clks - 1) @(posedge clk);
		end
	endtask

	// Waits for a start bit on tx, then samples each bit in its middle
	task automatic get_byte(output byte_t data, output logic ok);
		int   waited;
		logic seen;
		data = '0;
		ok = 1'b0;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < start_wait_cycles) begin
			@(negedge clk);
			if (!tx) seen = 1'b1;
			else waited++;
		end
		if (!seen) begin
			error_count++;
			$display("No start bit appeared on tx within %0d clock cycles", start_wait_cycles);
		end else begin
			repeat (bit_clks / 2) @(negedge clk);
			if (tx) begin
				error_count++;
				$display("Start bit on tx at %0t ended before mid-bit", $time);
			end else begin
				for (int i = 0; i < 8; i++) begin
					repeat (bit_clks) @(negedge clk);
					data[i] = tx;
				end
				repeat (bit_clks) @(negedge clk);
				if (!tx) begin
					error_count++;
					$display("Stop bit on tx at %0t was low", $time);
				end else begin
					ok = 1'b1;
				end
			end
		end
	endtask

	task automatic receive_and_check(input byte_t expected);
		byte_t got;
		logic  ok;
		get_byte(got, ok);
		if (ok) check_byte("tx byte", expected, got);
	endtask

	task automatic report_test(input string name, input int start_errors);
		if (error_count == start_errors) $display("%s: ok", name);
		else $display("%s: %0d errors", name, error_count - start_errors);
	endtask

	// Echo of one byte is the byte plus one, led shows the byte inverted
	task automatic echo_one(input byte_t data);
		fork
			send_byte(data);
			receive_and_check(byte_t'(data + 8'd1));
		join
		check_led(~data, led);
	endtask

	task automatic after_reset();
		int start_errors;
		start_errors = error_count;
		@(negedge clk);
		check_led(8'hFF, led);
		// Prompt character
		receive_and_check(8'h3F);
		report_test("after reset", start_errors);
	endtask

	task automatic single_letter();
		int start_errors;
		start_errors = error_count;
		echo_one(8'h41);
		report_test("single letter", start_errors);
	endtask

	task automatic zero_byte();
		int start_errors;
		start_errors = error_count;
		fork
			send_byte(8'h00);
			begin
				// Marker character before the echo
				receive_and_check(8'h21);
				receive_and_check(8'h01);
			end
		join
		check_led(8'hFF, led);
		report_test("zero byte", start_errors);
	endtask

	task automatic wrapping_increment();
		int start_errors;
		start_errors = error_count;
		echo_one(8'hFF);
		report_test("wrapping increment", start_errors);
	endtask

	task automatic random_bytes();
		int    start_errors;
		byte_t data;
		start_errors = error_count;
		for (int i = 0; i < 20; i++) begin
			data = byte_t'($urandom);
			while (data == 8'h00) data = byte_t'($urandom);
			echo_one(data);
		end
		report_test("random bytes", start_errors);
	endtask

	// Second byte arrives while the first echo is still on tx
	task automatic back_pressure();
		int start_errors;
		start_errors = error_count;
		fork
			begin
				send_byte(8'h5A);
				send_byte(8'h3C);
			end
			begin
				receive_and_check(8'h5B);
				receive_and_check(8'h3D);
			end
		join
		check_led(~8'h3C, led);
		report_test("back pressure", start_errors);
	endtask

	initial begin
		#(watchdog_time);
		$display("Watchdog expired after %0d time units, the tests did not finish", watchdog_time);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 32'h2bb7_2d99;
		void'($urandom(seed));
		error_count = 0;
		check_count = 0;
		reset = 1'b0;
		rx = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b1;
		after_reset();
		single_letter();
		zero_byte();
		wrapping_increment();
		random_bytes();
		back_pressure();
		assert_failures = forth_proc_i.core_i.asserts_i.failures;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			check_count, error_count, assert_failures);
		if (error_count == 0 && assert_failures == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/forth_proc_asserts.sv
// Bus and UART handshake checks, bound into every forth_core instance.
// failures counts the assertions that fired.
`default_nettype none

module forth_proc_asserts (
	input logic             clk,
	input logic             reset,
	input logic             cyc,
	input logic             stb,
	input forth_pkg::addr_t adr,
	input logic             ack,
	input logic             tx_start,
	input logic             tx_busy,
	input logic             rx_take,
	input logic             rx_valid
);
	int failures = 0;

	ack_in_cycle: assert property (@(posedge clk) disable iff (!reset)
		ack |-> cyc && stb)
		else begin
			failures++;
			$error("ack without cyc and stb");
		end

	// Request held with the same address until the ROM answers
	stb_held: assert property (@(posedge clk) disable iff (!reset)
		stb && !ack |=> stb && $stable(adr))
		else begin
			failures++;
			$error("stb or adr changed before ack");
		end

	// Transmitter idle on the pulse and busy right after it
	tx_start_idle: assert property (@(posedge clk) disable iff (!reset)
		tx_start |-> !tx_busy ##1 tx_busy)
		else begin
			failures++;
			$error("tx_start while tx_busy or not accepted");
		end

	// Received byte stays offered until the core takes it
	rx_valid_held: assert property (@(posedge clk) disable iff (!reset)
		rx_valid && !rx_take |=> rx_valid)
		else begin
			failures++;
			$error("rx_valid dropped before rx_take");
		end

endmodule

bind forth_core forth_proc_asserts asserts_i (
	.clk     (clk),
	.reset   (reset),
	.cyc     (cyc),
	.stb     (stb),
	.adr     (adr),
	.ack     (ack),
	.tx_start(tx_start),
	.tx_busy (tx_busy),
	.rx_take (rx_take),
	.rx_valid(rx_valid)
);

`default_nettype wire

// File: verilog/forth_proc.sv
// Stack processor top, core plus boot ROM and an 8N1 UART.
// Reset comes from a pin, asynchronous and active low.
// led is active low, all ones after reset.
`default_nettype none

module forth_proc #(
	parameter int clks_per_bit = forth_pkg::def_clks_per_bit,
	parameter int dstack_depth = forth_pkg::def_dstack_depth,
	parameter int rstack_depth = forth_pkg::def_rstack_depth
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic       tx,
	output logic [7:0] led
);
	import forth_pkg::*;

	logic  cyc;
	logic  stb;
	logic  ack;
	addr_t adr;
	cell_t dat;
	logic  rx_valid;
	logic  rx_take;
	byte_t rx_data;
	logic  tx_start;
	logic  tx_busy;
	byte_t tx_data;

	forth_core #(
		.dstack_depth(dstack_depth),
		.rstack_depth(rstack_depth)
	) core_i (
		.clk     (clk),
		.reset   (reset),
		.cyc     (cyc),
		.stb     (stb),
		.adr     (adr),
		.ack     (ack),
		.dat     (dat),
		.rx_valid(rx_valid),
		.rx_data (rx_data),
		.rx_take (rx_take),
		.tx_start(tx_start),
		.tx_data (tx_data),
		.tx_busy (tx_busy),
		.led     (led)
	);

	boot_rom rom_i (
		.clk  (clk),
		.reset(reset),
		.cyc  (cyc),
		.stb  (stb),
		.adr  (adr),
		.ack  (ack),
		.dat  (dat)
	);

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) rx_i (
		.clk     (clk),
		.reset   (reset),
		.rx      (rx),
		.rx_take (rx_take),
		.rx_valid(rx_valid),
		.rx_data (rx_data)
	);

	uart_tx #(
		.clks_per_bit(clks_per_bit)
	) tx_i (
		.clk     (clk),
		.reset   (reset),
		.tx_start(tx_start),
		.tx_data (tx_data),
		.tx_busy (tx_busy),
		.tx      (tx)
	);

endmodule

`default_nettype wire

// File: uart/uart_tx.sv
// 8N1 transmitter, LSB first, start bit one cycle after an accepted tx_start.
// tx_start is ignored while tx_busy is high.
`default_nettype none

module uart_tx #(
	parameter int clks_per_bit = forth_pkg::def_clks_per_bit
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             tx_start,
	input  forth_pkg::byte_t tx_data,
	output logic             tx_busy,
	output logic             tx
);
	localparam int cnt_w = $clog2(clks_per_bit);

	logic [cnt_w-1:0] cnt;
	logic [3:0]       bit_idx;
	logic [8:0]       shift;
	logic             accept;
	logic             bit_end;

	assign accept  = tx_start && !tx_busy;
	assign bit_end = tx_busy && cnt == cnt_w'(clks_per_bit - 1);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			tx      <= 1'b1;
			tx_busy <= 1'b0;
			cnt     <= '0;
			bit_idx <= '0;
		end else if (accept) begin
			tx      <= 1'b0;
			tx_busy <= 1'b1;
			cnt     <= '0;
			bit_idx <= '0;
		end else if (bit_end) begin
			cnt <= '0;
			// Index 9 is the stop bit, busy ends with it
			if (bit_idx == 4'd9) begin
				tx_busy <= 1'b0;
			end else begin
				tx      <= shift[0];
				bit_idx <= bit_idx + 1'b1;
			end
		end else if (tx_busy) begin
			cnt <= cnt + 1'b1;
		end
	end

	// Data bits then the stop bit
	always_ff @(posedge clk) begin
		if (accept) begin
			shift <= {1'b1, tx_data};
		end else if (bit_end) begin
			shift <= shift >> 1;
		end
	end

endmodule

`default_nettype wire

// File: uart/uart_rx.sv
// 8N1 receiver, samples at mid-bit after a two-flop synchronizer.
// Holds one byte until rx_take, a newer frame overwrites an unread byte.
// A frame with a low stop bit is dropped.
`default_nettype none

module uart_rx #(
	parameter int clks_per_bit = forth_pkg::def_clks_per_bit
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             rx,
	input  logic             rx_take,
	output logic             rx_valid,
	output forth_pkg::byte_t rx_data
);
	import forth_pkg::*;

	localparam int cnt_w = $clog2(clks_per_bit);

	typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_e;

	state_e           state;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_last;
	logic [cnt_w-1:0] cnt;
	logic [2:0]       bit_idx;
	byte_t            shift;
	logic             bit_tick;
	logic             frame_done;

	assign bit_tick   = cnt == cnt_w'(clks_per_bit - 1);
	assign frame_done = state == st_stop && bit_tick && rx_sync;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rx_meta  <= 1'b1;
			rx_sync  <= 1'b1;
			rx_last  <= 1'b1;
			state    <= st_idle;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_last <= rx_sync;
			cnt     <= cnt + 1'b1;
			case (state)
				st_idle: if (rx_last && !rx_sync) begin
					state <= st_start;
					cnt   <= '0;
				end
				// Half a bit in, confirm the start bit
				st_start: if (cnt == cnt_w'(clks_per_bit / 2 - 1)) begin
					state   <= rx_sync ? st_idle : st_data;
					cnt     <= '0;
					bit_idx <= '0;
				end
				st_data: if (bit_tick) begin
					cnt     <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) begin
						state <= st_stop;
					end
				end
				st_stop: if (bit_tick) begin
					state <= st_idle;
				end
				default: state <= st_idle;
			endcase
			if (frame_done) begin
				rx_valid <= 1'b1;
			end else if (rx_take) begin
				rx_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_data && bit_tick) begin
			shift <= {rx_sync, shift[7:1]};
		end
		if (frame_done) begin
			rx_data <= shift;
		end
	end

endmodule

`default_nettype wire

// File: verilog/boot_rom.sv
// Read-only Wishbone classic slave holding the fixed boot program.
// Ack and data are registered, one cycle after the strobe, and last one cycle.
// Addresses outside the program read as exit.
`default_nettype none

module boot_rom (
	input  logic             clk,
	input  logic             reset,
	input  logic             cyc,
	input  logic             stb,
	input  forth_pkg::addr_t adr,
	output logic             ack,
	output forth_pkg::cell_t dat
);
	import forth_pkg::*;

	function automatic cell_t op_cell(op_e op);
		return cell_t'(op);
	endfunction

	function automatic cell_t call_cell(addr_t target);
		return {1'b1, {(cell_w - addr_w - 1){1'b0}}, target};
	endfunction

	function automatic cell_t rom_cell(addr_t a);
		case (a)
			0:       return op_cell(op_lit);
			1:       return cell_t'("?");
			2:       return op_cell(op_emit);
			// Main loop
			3:       return op_cell(op_key);
			4:       return op_cell(op_dup);
			5:       return op_cell(op_zero_equal);
			6:       return op_cell(op_zero_branch);
			7:       return cell_t'(11);
			8:       return op_cell(op_lit);
			9:       return cell_t'("!");
			10:      return op_cell(op_emit);
			11:      return call_cell(addr_t'(16));
			12:      return op_cell(op_branch);
			13:      return cell_t'(3);
			// Echo subroutine, shows the byte and sends it plus one
			16:      return op_cell(op_dup);
			17:      return op_cell(op_io_led);
			18:      return op_cell(op_one_plus);
			19:      return op_cell(op_emit);
			default: return op_cell(op_exit);
		endcase
	endfunction

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ack <= 1'b0;
		end else begin
			ack <= cyc && stb && !ack;
		end
	end

	always_ff @(posedge clk) begin
		if (cyc && stb) begin
			dat <= rom_cell(adr);
		end
	end

endmodule

`default_nettype wire

// File: core/forth_core.sv
// Fetch/execute unit, one Wishbone read per opcode plus one for an inline operand.
// Requests are separated by at least one idle cycle after each ack.
// key and emit hold in wait_io until the UART handshake completes.
// LEDs are active low, led holds the inverse of the value written.
`default_nettype none

module forth_core #(
	parameter int dstack_depth = forth_pkg::def_dstack_depth,
	parameter int rstack_depth = forth_pkg::def_rstack_depth
) (
	input  logic             clk,
	input  logic             reset,
	output logic             cyc,
	output logic             stb,
	output forth_pkg::addr_t adr,
	input  logic             ack,
	input  forth_pkg::cell_t dat,
	input  logic             rx_valid,
	input  forth_pkg::byte_t rx_data,
	output logic             rx_take,
	output logic             tx_start,
	output forth_pkg::byte_t tx_data,
	input  logic             tx_busy,
	output logic [7:0]       led
);
	import forth_pkg::*;

	typedef enum logic [1:0] {st_fetch, st_operand, st_wait_io} state_e;

	state_e state;
	op_e    op;
	op_e    cur_op;
	addr_t  pc;
	logic   req;
	logic   is_call;
	logic   fetch_ack;
	logic   operand_ack;
	logic   d_push;
	logic   d_pop;
	logic   d_write;
	cell_t  d_din;
	cell_t  d_top;
	logic   r_push;
	logic   r_pop;
	addr_t  r_din;
	addr_t  r_top;

	assign cyc = req;
	assign stb = req;
	assign adr = pc;

	assign fetch_ack   = ack && state == st_fetch;
	assign operand_ack = ack && state == st_operand;
	assign is_call     = dat[cell_w-1];
	assign cur_op      = op_e'(dat[15:0]);

	// Return stack holds the address after the call cell
	assign r_push  = fetch_ack && is_call;
	assign r_pop   = fetch_ack && !is_call && cur_op == op_exit;
	assign r_din   = pc + 1'b1;
	assign tx_data = d_top[7:0];

	// Data stack control and UART handshakes
	always_comb begin
		d_push   = 1'b0;
		d_pop    = 1'b0;
		d_write  = 1'b0;
		d_din    = d_top;
		rx_take  = 1'b0;
		tx_start = 1'b0;
		if (fetch_ack && !is_call) begin
			case (cur_op)
				op_dup: d_push = 1'b1;
				op_drop, op_io_led: d_pop = 1'b1;
				op_one_plus: begin
					d_write = 1'b1;
					d_din   = d_top + 1'b1;
				end
				op_zero_equal: begin
					d_write = 1'b1;
					d_din   = (d_top == '0) ? '1 : '0;
				end
				default: ;
			endcase
		end
		if (operand_ack && op == op_lit) begin
			d_push = 1'b1;
			d_din  = dat;
		end
		// Flag is consumed whether or not the branch is taken
		if (operand_ack && op == op_zero_branch) begin
			d_pop = 1'b1;
		end
		if (state == st_wait_io && op == op_key && rx_valid) begin
			rx_take = 1'b1;
			d_push  = 1'b1;
			d_din   = cell_t'(rx_data);
		end
		if (state == st_wait_io && op == op_emit && !tx_busy) begin
			tx_start = 1'b1;
			d_pop    = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_fetch;
			op    <= op_exit;
			pc    <= '0;
			req   <= 1'b0;
			led   <= '1;
		end else begin
			// Drop the request after ack, raise it again one cycle later
			if (ack) begin
				req <= 1'b0;
			end else if (state != st_wait_io) begin
				req <= 1'b1;
			end

			if (fetch_ack && is_call) begin
				pc <= dat[addr_w-1:0];
			end else if (fetch_ack) begin
				op <= cur_op;
				case (cur_op)
					op_lit, op_branch, op_zero_branch: begin
						pc    <= pc + 1'b1;
						state <= st_operand;
					end
					op_key, op_emit: begin
						pc    <= pc + 1'b1;
						state <= st_wait_io;
					end
					op_exit: pc <= r_top;
					op_io_led: begin
						led <= ~d_top[7:0];
						pc  <= pc + 1'b1;
					end
					default: pc <= pc + 1'b1;
				endcase
			end

			if (operand_ack) begin
				state <= st_fetch;
				if (op == op_branch || (op == op_zero_branch && d_top == '0)) begin
					pc <= dat[addr_w-1:0];
				end else begin
					pc <= pc + 1'b1;
				end
			end

			if (rx_take || tx_start) begin
				state <= st_fetch;
			end
		end
	end

	lifo_stack #(
		.depth    (dstack_depth),
		.payload_t(cell_t)
	) data_stack (
		.clk      (clk),
		.reset    (reset),
		.push     (d_push),
		.pop      (d_pop),
		.write_top(d_write),
		.din      (d_din),
		.top      (d_top),
		.next     ()
	);

	lifo_stack #(
		.depth    (rstack_depth),
		.payload_t(addr_t)
	) return_stack (
		.clk      (clk),
		.reset    (reset),
		.push     (r_push),
		.pop      (r_pop),
		.write_top(1'b0),
		.din      (r_din),
		.top      (r_top),
		.next     ()
	);

endmodule

`default_nettype wire

// File: core/lifo_stack.sv
// Circular stack, the pointer wraps so overflow and underflow are silent.
// depth must be a power of two. top and next read combinationally.
// pop together with write_top stores din into the entry below the old top.
`default_nettype none

module lifo_stack #(
	parameter int  depth     = 16,
	parameter type payload_t = logic [31:0]
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  logic     pop,
	input  logic     write_top,
	input  payload_t din,
	output payload_t top,
	output payload_t next
);
	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	payload_t         mem [depth];
	logic [ptr_w-1:0] ptr;
	logic [ptr_w-1:0] ptr_up;
	logic [ptr_w-1:0] ptr_dn;

	assign ptr_up = ptr + 1'b1;
	assign ptr_dn = ptr - 1'b1;

	assign top  = mem[ptr];
	assign next = mem[ptr_dn];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr_up;
		end else if (pop) begin
			ptr <= ptr_dn;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr_up] <= din;
		end else if (pop && write_top) begin
			mem[ptr_dn] <= din;
		end else if (write_top) begin
			mem[ptr] <= din;
		end
	end

endmodule

`default_nettype wire

// File: common/forth_pkg.sv
// Shared widths, types and opcode encoding for the stack processor.
// A ROM cell with its top bit set is a call, its low addr_w bits give the target.
// Only the opcodes used by the boot program are encoded.
`default_nettype none

package forth_pkg;

	// Data cell and program address widths
	localparam int cell_w = 32;
	localparam int addr_w = 9;

	typedef logic [cell_w-1:0] cell_t;
	typedef logic [addr_w-1:0] addr_t;
	typedef logic [7:0]        byte_t;

	// Opcodes sit in the low 16 bits of a ROM cell
	typedef enum logic [15:0] {
		op_lit,
		op_dup,
		op_drop,
		op_one_plus,
		op_zero_equal,
		op_zero_branch,
		op_branch,
		op_emit,
		op_key,
		op_io_led,
		op_exit
	} op_e;

	// 19200 baud from a 12 MHz clock
	localparam int def_clks_per_bit = 625;

	// Stack depths, powers of two so the pointers wrap
	localparam int def_dstack_depth = 16;
	localparam int def_rstack_depth = 8;

endpackage

`default_nettype wire
